//--- common/pu_pkg.sv
`default_nettype none

package pu_pkg;

  // =========================================================================
  // widths
  // =========================================================================
  localparam int inst_w        = 32;
  localparam int imm_w         = 16;
  localparam int stride_w      = 32;             // hi half + lo half
  localparam int op_code_w     = 4;
  localparam int op_spec_w     = 7;
  localparam int loop_id_w     = 5;
  localparam int imem_addr_w   = 10;             // 1024 words
  localparam int fn_w          = 3;
  localparam int rf_addr_w     = 4;
  localparam int alu_word_w    = 28;             // low bits of a compute inst
  localparam int mem_type_w    = 2;
  localparam int iter_type_w   = 3;
  localparam int stride_type_w = 4;
  localparam int state_w       = 3;
  localparam int stream_sel_w  = 3;

  // instruction fields, top down: op_code, op_spec, loop_id, imm
  localparam int op_spec_lsb = imm_w + loop_id_w;
  localparam int op_code_lsb = op_spec_lsb + op_spec_w;

  // =========================================================================
  // opcodes
  // =========================================================================
  localparam logic [op_code_w-1:0] op_ldmem        = 4'd1;
  localparam logic [op_code_w-1:0] op_genaddr_hi   = 4'd5;
  localparam logic [op_code_w-1:0] op_genaddr_lo   = 4'd6;
  localparam logic [op_code_w-1:0] op_loop         = 4'd7;
  localparam logic [op_code_w-1:0] op_block_repeat = 4'd8;
  localparam logic [op_code_w-1:0] op_compute_r    = 4'd11;
  localparam logic [op_code_w-1:0] op_compute_i    = 4'd12;

  // block states, codes 2, 3 and 6 unused
  localparam logic [state_w-1:0] st_idle         = 3'd0;
  localparam logic [state_w-1:0] st_decode       = 3'd1;
  localparam logic [state_w-1:0] st_compute_wait = 3'd4;
  localparam logic [state_w-1:0] st_compute      = 3'd5;
  localparam logic [state_w-1:0] st_done         = 3'd7;

  // stream selectors, valid when rf addr bit 3 is set
  localparam logic [stream_sel_w-1:0] ld_obuf = 3'd0;
  localparam logic [stream_sel_w-1:0] ld0_ddr = 3'd1;
  localparam logic [stream_sel_w-1:0] ld1_ddr = 3'd2;

endpackage

`default_nettype wire

//--- hdl/pu_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module pu_ctrl_fsm import pu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               pu_block_start,
  input  logic               pu_compute_start,
  input  logic               inst_wr_req,
  input  logic [inst_w-1:0]  inst_wr_data,
  input  logic               stall,
  input  logic               issue_last,
  output logic [state_w-1:0] state,
  output logic               pu_compute_ready,
  output logic               done,
  output logic               inst_wr_ready
);

  logic [state_w-1:0] state_nxt;
  logic [imm_w-1:0]   repeat_cnt;      // passes left after the current one
  logic [imm_w-1:0]   repeat_cnt_nxt;
  logic               block_end;
  logic               last_issue;

  assign block_end  = inst_wr_req &&
                      (inst_wr_data[op_code_lsb +: op_code_w] == op_block_repeat);
  assign last_issue = issue_last && !stall;

  // =========================================================================
  // block sequencing
  // =========================================================================
  always_comb begin
    state_nxt      = state;
    repeat_cnt_nxt = repeat_cnt;
    case (state)
      st_idle: begin
        if (pu_block_start) state_nxt = st_decode;
      end
      st_decode: begin
        if (block_end) begin
          state_nxt      = st_compute_wait;
          repeat_cnt_nxt = inst_wr_data[imm_w-1:0];  // R from imm
        end
      end
      st_compute_wait: begin
        if (pu_compute_start) state_nxt = st_compute;
      end
      st_compute: begin
        if (last_issue) begin
          if (repeat_cnt == '0) state_nxt = st_done;
          else repeat_cnt_nxt = repeat_cnt - imm_w'(1);
        end
      end
      st_done: begin
        state_nxt = st_idle;                         // one-cycle done pulse
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      repeat_cnt <= '0;
    end else begin
      state      <= state_nxt;
      repeat_cnt <= repeat_cnt_nxt;
    end
  end

  assign pu_compute_ready = (state == st_compute_wait);
  assign done             = (state == st_done);
  assign inst_wr_ready    = (state != st_compute);

endmodule

`default_nettype wire

//--- hdl/pu_cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pu_cfg_decode import pu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [state_w-1:0]       state,
  input  logic                     inst_wr_req,
  input  logic [inst_w-1:0]        inst_wr_data,
  output logic                     cfg_loop_iter_v,
  output logic [imm_w-1:0]         cfg_loop_iter,
  output logic [iter_type_w-1:0]   cfg_loop_iter_type,
  output logic                     cfg_loop_stride_v,
  output logic [stride_w-1:0]      cfg_loop_stride,
  output logic [stride_type_w-1:0] cfg_loop_stride_type,
  output logic                     cfg_mem_req_v,
  output logic [mem_type_w-1:0]    cfg_mem_req_type
);

  logic [op_code_w-1:0]      op_code;
  logic [op_spec_w-1:0]      op_spec;
  logic [imm_w-1:0]          imm;
  logic                      inst_v;
  logic [stride_w-imm_w-1:0] stride_hi;

  assign op_code = inst_wr_data[op_code_lsb +: op_code_w];
  assign op_spec = inst_wr_data[op_spec_lsb +: op_spec_w];
  assign imm     = inst_wr_data[imm_w-1:0];
  assign inst_v  = (state == st_decode) && inst_wr_req;  // accepted word

  // =========================================================================
  // configuration pulses
  // =========================================================================
  assign cfg_loop_iter_v      = inst_v && (op_code == op_loop);
  assign cfg_loop_iter        = imm;
  assign cfg_loop_iter_type   = op_spec[iter_type_w-1:0];

  assign cfg_loop_stride_v    = inst_v && (op_code == op_genaddr_lo);
  assign cfg_loop_stride      = {stride_hi, imm};
  assign cfg_loop_stride_type = op_spec[stride_type_w-1:0];

  assign cfg_mem_req_v        = inst_v && (op_code == op_ldmem);
  assign cfg_mem_req_type     = op_spec[4:3];

  // upper stride half, consumed by the next lo instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      stride_hi <= '0;
    end else if (cfg_loop_stride_v || state == st_done) begin
      stride_hi <= '0;
    end else if (inst_v && op_code == op_genaddr_hi) begin
      stride_hi <= imm;
    end
  end

endmodule

`default_nettype wire

//--- compute/pu_inst_buf.sv
`timescale 1ns/1ps
`default_nettype none

module pu_inst_buf import pu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [state_w-1:0]    state,
  input  logic                  stall,
  input  logic                  inst_wr_req,
  input  logic [inst_w-1:0]     inst_wr_data,
  output logic [alu_word_w-1:0] issue_word,
  output logic                  issue_last
);

  logic [alu_word_w-1:0]  mem [0:(1<<imem_addr_w)-1];
  logic [imem_addr_w-1:0] wr_addr;
  logic [imem_addr_w-1:0] last_addr;   // address of the block's last word
  logic [imem_addr_w-1:0] cur_addr;    // address of issue_word
  logic [imem_addr_w-1:0] nxt_addr;
  logic [imem_addr_w-1:0] rd_addr;
  logic [op_code_w-1:0]   op_code;
  logic                   wr_en;
  logic                   rd_en;
  logic                   advance;

  assign op_code = inst_wr_data[op_code_lsb +: op_code_w];
  assign wr_en   = (state == st_decode) && inst_wr_req &&
                   (op_code == op_compute_r || op_code == op_compute_i);

  always_ff @(posedge clk) begin
    if (reset || state == st_done) begin
      wr_addr   <= '0;
      last_addr <= '0;
    end else if (wr_en) begin
      wr_addr   <= wr_addr + imem_addr_w'(1);
      last_addr <= wr_addr;
    end
  end

  // =========================================================================
  // replay, wraps after last_addr
  // =========================================================================
  assign advance  = (state == st_compute) && !stall;
  assign nxt_addr = (cur_addr == last_addr) ? '0 : cur_addr + imem_addr_w'(1);
  assign rd_addr  = advance ? nxt_addr : '0;         // word 0 prefetched in decode
  assign rd_en    = (state == st_decode) || advance;

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_addr <= '0;
    end else if (advance) begin
      cur_addr <= nxt_addr;
    end else if (state != st_compute) begin
      cur_addr <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= inst_wr_data[alu_word_w-1:0];
    if (rd_en) issue_word <= mem[rd_addr];
  end

  assign issue_last = (cur_addr == last_addr);

endmodule

`default_nettype wire

//--- compute/pu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module pu_issue import pu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [state_w-1:0]    state,
  input  logic [alu_word_w-1:0] issue_word,
  input  logic                  obuf_ld_stream_read_ready,
  input  logic                  ddr_ld0_stream_read_ready,
  input  logic                  ddr_ld1_stream_read_ready,
  input  logic                  ddr_st_stream_write_ready,
  output logic                  stall,
  output logic                  alu_fn_valid,
  output logic [fn_w-1:0]       alu_fn,
  output logic [rf_addr_w-1:0]  alu_in0_addr,
  output logic                  alu_in1_src,
  output logic [rf_addr_w-1:0]  alu_in1_addr,
  output logic [rf_addr_w-1:0]  alu_out_addr,
  output logic [imm_w-1:0]      alu_imm,
  output logic                  obuf_ld_stream_read_req,
  output logic                  ddr_ld0_stream_read_req,
  output logic                  ddr_ld1_stream_read_req,
  output logic                  ddr_st_stream_write_req
);

  logic active;
  logic issue;
  logic obuf_need;
  logic ld0_need;
  logic ld1_need;
  logic st_need;
  logic st_dly1;
  logic st_dly2;

  // true when either ALU operand reads stream sel
  function automatic logic needs_load(input logic [rf_addr_w-1:0]    in0,
                                      input logic                    in1_src,
                                      input logic [rf_addr_w-1:0]    in1,
                                      input logic [stream_sel_w-1:0] sel);
    logic in0_hit;
    logic in1_hit;
    in0_hit = in0[rf_addr_w-1] && (in0[stream_sel_w-1:0] == sel);
    in1_hit = !in1_src && in1[rf_addr_w-1] && (in1[stream_sel_w-1:0] == sel);
    return in0_hit || in1_hit;
  endfunction

  // =========================================================================
  // field split and stream needs
  // =========================================================================
  assign {alu_in1_src, alu_fn, alu_imm, alu_in0_addr, alu_out_addr} = issue_word;
  assign alu_in1_addr = alu_imm[rf_addr_w-1:0];

  assign active    = (state == st_compute);
  assign obuf_need = active && needs_load(alu_in0_addr, alu_in1_src, alu_in1_addr, ld_obuf);
  assign ld0_need  = active && needs_load(alu_in0_addr, alu_in1_src, alu_in1_addr, ld0_ddr);
  assign ld1_need  = active && needs_load(alu_in0_addr, alu_in1_src, alu_in1_addr, ld1_ddr);
  assign st_need   = active && alu_out_addr[rf_addr_w-1];

  // hold the word until every needed stream is ready
  assign stall = (obuf_need && !obuf_ld_stream_read_ready) ||
                 (ld0_need  && !ddr_ld0_stream_read_ready) ||
                 (ld1_need  && !ddr_ld1_stream_read_ready) ||
                 (st_need   && !ddr_st_stream_write_ready);

  assign issue        = active && !stall;
  assign alu_fn_valid = issue;

  assign obuf_ld_stream_read_req = obuf_need && !stall;
  assign ddr_ld0_stream_read_req = ld0_need && !stall;
  assign ddr_ld1_stream_read_req = ld1_need && !stall;

  // store data leaves the ALU two cycles after issue
  always_ff @(posedge clk) begin
    if (reset) begin
      st_dly1 <= 1'b0;
      st_dly2 <= 1'b0;
    end else begin
      st_dly1 <= st_need && issue;
      st_dly2 <= st_dly1;
    end
  end

  assign ddr_st_stream_write_req = st_dly2;

endmodule

`default_nettype wire

//--- hdl/pu_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pu_ctrl_top import pu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     pu_block_start,
  input  logic                     pu_compute_start,
  input  logic                     inst_wr_req,
  input  logic [inst_w-1:0]        inst_wr_data,
  input  logic                     obuf_ld_stream_read_ready,
  input  logic                     ddr_ld0_stream_read_ready,
  input  logic                     ddr_ld1_stream_read_ready,
  input  logic                     ddr_st_stream_write_ready,
  output logic [state_w-1:0]       pu_ctrl_state,
  output logic                     pu_compute_ready,
  output logic                     done,
  output logic                     inst_wr_ready,
  output logic                     cfg_loop_iter_v,
  output logic [imm_w-1:0]         cfg_loop_iter,
  output logic [iter_type_w-1:0]   cfg_loop_iter_type,
  output logic                     cfg_loop_stride_v,
  output logic [stride_w-1:0]      cfg_loop_stride,
  output logic [stride_type_w-1:0] cfg_loop_stride_type,
  output logic                     cfg_mem_req_v,
  output logic [mem_type_w-1:0]    cfg_mem_req_type,
  output logic                     alu_fn_valid,
  output logic [fn_w-1:0]          alu_fn,
  output logic [rf_addr_w-1:0]     alu_in0_addr,
  output logic                     alu_in1_src,
  output logic [rf_addr_w-1:0]     alu_in1_addr,
  output logic [rf_addr_w-1:0]     alu_out_addr,
  output logic [imm_w-1:0]         alu_imm,
  output logic                     obuf_ld_stream_read_req,
  output logic                     ddr_ld0_stream_read_req,
  output logic                     ddr_ld1_stream_read_req,
  output logic                     ddr_st_stream_write_req
);

  // =========================================================================
  // internal nets between the four blocks
  // =========================================================================
  logic                  stall;        // issue -> fsm, inst buf
  logic                  issue_last;   // inst buf -> fsm
  logic [alu_word_w-1:0] issue_word;   // inst buf -> issue

  pu_ctrl_fsm u_fsm (
    .state (pu_ctrl_state),
    .*
  );

  pu_cfg_decode u_cfg_decode (
    .state (pu_ctrl_state),
    .*
  );

  pu_inst_buf u_inst_buf (
    .state (pu_ctrl_state),
    .*
  );

  pu_issue u_issue (
    .state (pu_ctrl_state),
    .*
  );

endmodule

`default_nettype wire

//--- tb/pu_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module pu_ctrl_props import pu_pkg::*; (
  input logic               clk,
  input logic               reset,
  input logic [state_w-1:0] pu_ctrl_state,
  input logic               pu_compute_ready,
  input logic               done,
  input logic               inst_wr_ready,
  input logic               alu_fn_valid,
  input logic               obuf_ld_stream_read_req,
  input logic               ddr_ld0_stream_read_req,
  input logic               ddr_ld1_stream_read_req,
  input logic               obuf_ld_stream_read_ready,
  input logic               ddr_ld0_stream_read_ready,
  input logic               ddr_ld1_stream_read_ready
);

  // ==========================================================================
  // handshake rules
  // ==========================================================================
  a_ready_no_issue: assert property (@(posedge clk) disable iff (reset)
    !(pu_compute_ready && alu_fn_valid))
    else $error("pu_compute_ready and alu_fn_valid high together");

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done held for more than one cycle");

  a_no_wr_in_compute: assert property (@(posedge clk) disable iff (reset)
    (pu_ctrl_state == st_compute) |-> !inst_wr_ready)
    else $error("inst_wr_ready high during compute");

  // a load request only goes out to a ready stream
  a_obuf_req: assert property (@(posedge clk) disable iff (reset)
    obuf_ld_stream_read_req |-> obuf_ld_stream_read_ready)
    else $error("obuf load request while not ready");

  a_ld0_req: assert property (@(posedge clk) disable iff (reset)
    ddr_ld0_stream_read_req |-> ddr_ld0_stream_read_ready)
    else $error("ddr ld0 load request while not ready");

  a_ld1_req: assert property (@(posedge clk) disable iff (reset)
    ddr_ld1_stream_read_req |-> ddr_ld1_stream_read_ready)
    else $error("ddr ld1 load request while not ready");

endmodule

bind pu_ctrl_top pu_ctrl_props u_props (.*);

`default_nettype wire

//--- tb/pu_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pu_ctrl_tb import pu_pkg::*; ();

  localparam int          n_blocks   = 3;
  localparam int          max_cycles = 10 * (n_blocks * 16 * 4 * 2) + 160;  // 4000
  localparam logic [31:0] lfsr_taps  = 32'h80200003;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     pu_block_start;
  logic                     pu_compute_start;
  logic                     inst_wr_req;
  logic [inst_w-1:0]        inst_wr_data;
  logic                     obuf_ld_stream_read_ready;
  logic                     ddr_ld0_stream_read_ready;
  logic                     ddr_ld1_stream_read_ready;
  logic                     ddr_st_stream_write_ready;
  logic [state_w-1:0]       pu_ctrl_state;
  logic                     pu_compute_ready;
  logic                     done;
  logic                     inst_wr_ready;
  logic                     cfg_loop_iter_v;
  logic [imm_w-1:0]         cfg_loop_iter;
  logic [iter_type_w-1:0]   cfg_loop_iter_type;
  logic                     cfg_loop_stride_v;
  logic [stride_w-1:0]      cfg_loop_stride;
  logic [stride_type_w-1:0] cfg_loop_stride_type;
  logic                     cfg_mem_req_v;
  logic [mem_type_w-1:0]    cfg_mem_req_type;
  logic                     alu_fn_valid;
  logic [fn_w-1:0]          alu_fn;
  logic [rf_addr_w-1:0]     alu_in0_addr;
  logic                     alu_in1_src;
  logic [rf_addr_w-1:0]     alu_in1_addr;
  logic [rf_addr_w-1:0]     alu_out_addr;
  logic [imm_w-1:0]         alu_imm;
  logic                     obuf_ld_stream_read_req;
  logic                     ddr_ld0_stream_read_req;
  logic                     ddr_ld1_stream_read_req;
  logic                     ddr_st_stream_write_req;

  logic [31:0] lfsr = 32'he1bb6e8d;
  logic [3:0]  ready_pat [0:1023];   // {st, ld1, ld0, obuf}
  logic [35:0] exp_q [$];            // {word, in1_addr, needs}
  logic [15:0] exp_hi = '0;          // stride high half model
  logic        rand_ready = 1'b0;
  int          cyc = 0;
  int          val_errs = 0;
  int          proto_errs = 0;
  int          cnt_exp [3] = '{0, 0, 0};
  int          cnt_got [3] = '{0, 0, 0};

  pu_ctrl_top u_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return v;
  endfunction

  // expected fields and stream needs of one compute word
  function automatic logic [35:0] ref_issue(input logic [27:0] w);
    logic [3:0] in0;
    logic [3:0] in1;
    logic [3:0] need;
    in0 = w[7:4];
    in1 = w[11:8];                   // low bits of imm
    for (int s = 0; s < 3; s++) begin
      need[s] = (in0[3] && in0[2:0] == 3'(s)) || (!w[27] && in1[3] && in1[2:0] == 3'(s));
    end
    need[3] = w[3];                  // out_addr names the store stream
    return {w, in1, need};
  endfunction

  task automatic compare_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      val_errs++;
      $display("error %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      proto_errs++;
      $display("%s at cycle %0d", what, cyc);
    end
  endtask

  // one instruction per cycle and cfg outputs checked mid-cycle
  task automatic send_inst(input logic [31:0] w);
    logic [3:0]  op;
    logic [6:0]  spec;
    logic [15:0] imm;
    op   = w[31:28];
    spec = w[27:21];
    imm  = w[15:0];
    @(posedge clk);
    #1;
    inst_wr_req  = 1'b1;
    inst_wr_data = w;
    @(negedge clk);
    compare_val("cfg_loop_iter_v", 32'(op == op_loop), 32'(cfg_loop_iter_v));
    compare_val("cfg_loop_stride_v", 32'(op == op_genaddr_lo), 32'(cfg_loop_stride_v));
    compare_val("cfg_mem_req_v", 32'(op == op_ldmem), 32'(cfg_mem_req_v));
    if (op == op_loop) begin
      compare_val("cfg_loop_iter", 32'(imm), 32'(cfg_loop_iter));
      compare_val("cfg_loop_iter_type", 32'(spec[2:0]), 32'(cfg_loop_iter_type));
    end
    if (op == op_genaddr_lo) begin
      compare_val("cfg_loop_stride", {exp_hi, imm}, cfg_loop_stride);
      compare_val("cfg_loop_stride_type", 32'(spec[3:0]), 32'(cfg_loop_stride_type));
      exp_hi = '0;
    end
    if (op == op_genaddr_hi) exp_hi = imm;
    if (op == op_ldmem) compare_val("cfg_mem_req_type", 32'(spec[4:3]), 32'(cfg_mem_req_type));
  endtask

  // ==========================================================================
  // one block of config, program and repeat, then compute until done
  // ==========================================================================
  task automatic run_block(input int n, input int r, input logic random);
    logic [27:0] prog [$];
    logic [31:0] w;
    @(posedge clk);
    #1 pu_block_start = 1'b1;
    @(posedge clk);
    #1 pu_block_start = 1'b0;
    send_inst({op_genaddr_lo, 28'(lfsr_bits(28))});   // no hi since done
    send_inst({op_genaddr_hi, 28'(lfsr_bits(28))});
    send_inst({op_genaddr_lo, 28'(lfsr_bits(28))});
    send_inst({op_genaddr_lo, 28'(lfsr_bits(28))});   // hi consumed by the lo before
    send_inst({op_loop, 28'(lfsr_bits(28))});
    send_inst({op_ldmem, 28'(lfsr_bits(28))});
    send_inst({op_genaddr_hi, 28'(lfsr_bits(28))});   // left open until done
    for (int i = 0; i < n; i++) begin
      w = lfsr_bits(29);
      prog.push_back(w[27:0]);
      send_inst({w[28] ? op_compute_i : op_compute_r, w[27:0]});
    end
    for (int rep = 0; rep <= r; rep++) begin
      foreach (prog[i]) exp_q.push_back(ref_issue(prog[i]));
    end
    send_inst({op_block_repeat, 12'(lfsr_bits(12)), 16'(r)});
    @(posedge clk);
    #1 inst_wr_req = 1'b0;
    do @(negedge clk); while (!pu_compute_ready);
    #1 rand_ready = random;
    @(posedge clk);
    #1 pu_compute_start = 1'b1;
    @(posedge clk);
    #1 pu_compute_start = 1'b0;
    do @(negedge clk); while (!done);
    #1 rand_ready = 1'b0;
    exp_hi = '0;                     // done clears the high half
  endtask

  // stream readies with about one stall in four per stream
  initial begin : ready_drive
    int idx;
    idx = 0;
    {ddr_st_stream_write_ready, ddr_ld1_stream_read_ready,
     ddr_ld0_stream_read_ready, obuf_ld_stream_read_ready} = 4'hf;
    forever begin
      @(posedge clk);
      #1;
      {ddr_st_stream_write_ready, ddr_ld1_stream_read_ready,
       ddr_ld0_stream_read_ready, obuf_ld_stream_read_ready} =
        rand_ready ? ready_pat[idx] : 4'hf;
      if (rand_ready) idx = (idx + 1) % 1024;
    end
  end

  always @(posedge clk) begin
    cyc++;
    if (cyc >= max_cycles) begin
      $display("timeout, no verdict after %0d cycles", cyc);
      $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
      $display("Some tests failed");
      $finish;
    end
  end

  // ==========================================================================
  // comparison of issue pulses, stream requests and handshake
  // ==========================================================================
  always @(negedge clk) begin : compare
    logic [35:0]        e;
    logic [3:0]         need;
    logic [2:0]         got_ld;
    logic [1:0]         st_hist;
    logic [state_w-1:0] exp_st;
    int                 last_issue;
    if (reset) begin
      st_hist    = '0;
      exp_st     = st_idle;
      last_issue = 0;
    end else begin
      compare_val("pu_ctrl_state", 32'(exp_st), 32'(pu_ctrl_state));
      compare_val("pu_compute_ready", 32'(exp_st == st_compute_wait), 32'(pu_compute_ready));
      compare_val("done", 32'(exp_st == st_done), 32'(done));
      compare_val("inst_wr_ready", 32'(exp_st != st_compute), 32'(inst_wr_ready));
      need = '0;
      if (alu_fn_valid) begin
        if (!rand_ready) expect_true(cyc == last_issue + 1, "issue pulses not back to back");
        last_issue = cyc;
        if (exp_q.size() == 0) begin
          expect_true(1'b0, "issue pulse with no expected word left");
        end else begin
          e    = exp_q.pop_front();
          need = e[3:0];
          compare_val("alu_in1_src", 32'(e[35]), 32'(alu_in1_src));
          compare_val("alu_fn", 32'(e[34:32]), 32'(alu_fn));
          compare_val("alu_imm", 32'(e[31:16]), 32'(alu_imm));
          compare_val("alu_in0_addr", 32'(e[15:12]), 32'(alu_in0_addr));
          compare_val("alu_out_addr", 32'(e[11:8]), 32'(alu_out_addr));
          compare_val("alu_in1_addr", 32'(e[7:4]), 32'(alu_in1_addr));
        end
      end
      got_ld = {ddr_ld1_stream_read_req, ddr_ld0_stream_read_req, obuf_ld_stream_read_req};
      compare_val("obuf_ld_stream_read_req", 32'(need[0]), 32'(got_ld[0]));
      compare_val("ddr_ld0_stream_read_req", 32'(need[1]), 32'(got_ld[1]));
      compare_val("ddr_ld1_stream_read_req", 32'(need[2]), 32'(got_ld[2]));
      for (int i = 0; i < 3; i++) begin
        if (need[i]) cnt_exp[i]++;
        if (got_ld[i]) cnt_got[i]++;
      end
      expect_true(!got_ld[0] || obuf_ld_stream_read_ready, "obuf request while not ready");
      expect_true(!got_ld[1] || ddr_ld0_stream_read_ready, "ld0 request while not ready");
      expect_true(!got_ld[2] || ddr_ld1_stream_read_ready, "ld1 request while not ready");
      compare_val("ddr_st_stream_write_req", 32'(st_hist[1]), 32'(ddr_st_stream_write_req));
      st_hist = {st_hist[0], need[3]};
      if (!inst_wr_req) begin
        expect_true(!(cfg_loop_iter_v || cfg_loop_stride_v || cfg_mem_req_v),
                    "config pulse without an instruction");
      end
      if (exp_st == st_compute_wait && pu_compute_start) begin
        last_issue = cyc;            // first issue due next cycle
      end
      if (done) begin
        expect_true(cyc == last_issue + 1, "done not one cycle after the last issue");
        expect_true(exp_q.size() == 0, "done with expected issues left");
      end
      // block sequence the controller has to follow
      case (exp_st)
        st_idle: begin
          if (pu_block_start) exp_st = st_decode;
        end
        st_decode: begin
          if (inst_wr_req && inst_wr_data[31:28] == op_block_repeat) begin
            exp_st = st_compute_wait;
          end
        end
        st_compute_wait: begin
          if (pu_compute_start) exp_st = st_compute;
        end
        st_compute: begin
          if (alu_fn_valid && exp_q.size() == 0) exp_st = st_done;
        end
        default: begin
          exp_st = st_idle;
        end
      endcase
    end
  end

  initial begin
    logic [31:0] r;
    reset            = 1'b1;
    pu_block_start   = 1'b0;
    pu_compute_start = 1'b0;
    inst_wr_req      = 1'b0;
    inst_wr_data     = '0;
    for (int i = 0; i < 1024; i++) begin
      r            = lfsr_bits(8);
      ready_pat[i] = {|r[7:6], |r[5:4], |r[3:2], |r[1:0]};
    end
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    run_block(10, 1, 1'b0);          // all ready
    run_block(12, 3, 1'b1);          // random back-pressure
    run_block(4, 2, 1'b0);           // shorter program after done
    repeat (4) @(negedge clk);
    expect_true(exp_q.size() == 0, "expected issues never seen");
    compare_val("obuf request count", cnt_exp[0], cnt_got[0]);
    compare_val("ld0 request count", cnt_exp[1], cnt_got[1]);
    compare_val("ld1 request count", cnt_exp[2], cnt_got[2]);
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/pu_pkg.sv
hdl/pu_ctrl_fsm.sv
hdl/pu_cfg_decode.sv
compute/pu_inst_buf.sv
compute/pu_issue.sv
hdl/pu_ctrl_top.sv
tb/pu_ctrl_props.sv
tb/pu_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pu_ctrl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
